/* run_sim.sh */
#!/bin/sh
# Build the multiplier testbench with Verilator, run it, and grade the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f sources.f \
    --top-module tb_booth_mult \
    --Mdir obj_dir \
    -o sim_booth_mult

./obj_dir/sim_booth_mult > sim.log 2>&1 || true
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
    echo "run_sim: testbench reported success"
    exit 0
else
    echo "run_sim: testbench reported failure, see sim.log"
    exit 1
fi

/* sources.f */
src/mult_pkg.sv
src/stream_pkg.sv
src/booth_recoder.sv
src/pp_skid_buffer.sv
src/cla_adder.sv
src/wallace_reducer.sv
src/booth_mult_top.sv
test/tb_booth_mult.sv

/* src/booth_mult_top.sv */
// top of the pipelined 64x64 booth multiplier, operand stream in and product stream out
module booth_mult_top
    import mult_pkg::*;
    import stream_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  mult_req_t req,
    input  logic      req_valid,
    output logic      req_ready,
    output product_t  product,
    output logic      product_valid,
    input  logic      product_ready
);

    pp_set_t pp_set;
    pp_set_t set_out;
    logic    set_valid;
    logic    set_ready;

    // ----------------------------------------------------------------------
    // recoder feeds the buffer directly, no register in between
    booth_recoder booth_recoder_i (
        .req    (req),
        .pp_set (pp_set)
    );

    pp_skid_buffer pp_skid_buffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .set_in    (pp_set),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .set_out   (set_out),
        .out_valid (set_valid),
        .out_ready (set_ready)
    );

    // tree, final add and the product register
    wallace_reducer wallace_reducer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .set_in        (set_out),
        .set_valid     (set_valid),
        .set_ready     (set_ready),
        .product       (product),
        .product_valid (product_valid),
        .product_ready (product_ready)
    );

endmodule

/* src/booth_recoder.sv */
// radix-4 booth recoding, combinational, turns one request into a partial product set
module booth_recoder
    import mult_pkg::*;
    import stream_pkg::*;
(
    input  mult_req_t req,
    output pp_set_t   pp_set
);

    logic         mcand_sign;
    logic         mplier_sign;
    ext_operand_t mcand_ext;
    ext_operand_t mplier_ext;
    logic [EXT_W:0] mplier_pad;

    // magnitude chosen by one digit, before any negation
    function automatic ext_operand_t booth_select(
        input booth_digit_t digit,
        input ext_operand_t x
    );
        ext_operand_t mag;
        case (digit)
            3'b001, 3'b010, 3'b101, 3'b110:
                mag = x;
            3'b011, 3'b100:
                mag = x << 1;
            default:
                mag = '0;
        endcase
        return mag;
    endfunction

    // ----------------------------------------------------------------------
    // operand extension

    // zeros when unsigned, sign copies when signed
    assign mcand_sign  = req.signed_mode & req.multiplicand[OPERAND_W-1];
    assign mplier_sign = req.signed_mode & req.multiplier[OPERAND_W-1];

    assign mcand_ext  = {{2{mcand_sign}}, req.multiplicand};
    assign mplier_ext = {{2{mplier_sign}}, req.multiplier};

    // implicit zero below bit 0 for the first window
    assign mplier_pad = {mplier_ext, 1'b0};

    // ----------------------------------------------------------------------
    // one row per overlapping window
    for (genvar i = 0; i < NUM_PP; i++)
    begin : gen_row
        booth_digit_t digit;
        ext_operand_t row;
        logic         neg;

        assign digit = mplier_pad[2 * i +: 3];

        // 111 is a zero digit, kept positive
        assign neg = digit[2] & ~(digit[1] & digit[0]);

        // one's complement here, the +1 rides on sign_low
        assign row = booth_select(digit, mcand_ext) ^ {EXT_W{neg}};

        if (i == 0)
        begin : gen_first
            assign pp_set.rows[i] = {~row[EXT_W-1], row[EXT_W-1], row};
        end
        else
        begin : gen_rest
            // leading one and inverted sign replace the sign extension
            assign pp_set.rows[i] = {1'b0, 1'b1, ~row[EXT_W-1], row[EXT_W-2:0]};
        end

        assign pp_set.sign_low[i] = neg;
    end

endmodule

/* src/cla_adder.sv */
// 128-bit two-level carry lookahead adder for the final carry-save rows, wraps modulo 2^128
module cla_adder
    import mult_pkg::*;
(
    input  product_t a,
    input  product_t b,
    output product_t sum
);

    product_t gen;
    product_t prop;
    product_t carry;
    logic [LA_BLOCKS-1:0] blk_g;
    logic [LA_BLOCKS-1:0] blk_p;
    logic [LA_BLOCKS-1:0] blk_c;
    logic [LA_SUPERS-1:0] sup_g;
    logic [LA_SUPERS-1:0] sup_p;
    logic [LA_SUPERS-1:0] sup_c;

    // carries into each of four positions, c[0] is the group carry-in
    function automatic la_group_t la_carries(
        input la_group_t g,
        input la_group_t p,
        input logic      cin
    );
        la_group_t c;
        c[0] = cin;
        c[1] = g[0] | (p[0] & cin);
        c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
        c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);
        return c;
    endfunction

    // group generate and propagate
    function automatic logic [1:0] la_group(input la_group_t g, input la_group_t p);
        logic gg;
        gg = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
        return {gg, &p};
    endfunction

    assign gen  = a & b;
    assign prop = a ^ b;

    // ----------------------------------------------------------------------
    // first level, bits inside 4-bit blocks
    for (genvar k = 0; k < LA_BLOCKS; k++)
    begin : gen_block
        assign carry[4 * k +: 4] = la_carries(gen[4 * k +: 4], prop[4 * k +: 4], blk_c[k]);
        assign {blk_g[k], blk_p[k]} = la_group(gen[4 * k +: 4], prop[4 * k +: 4]);
    end

    // ----------------------------------------------------------------------
    // second level, blocks inside 16-bit superblocks
    for (genvar s = 0; s < LA_SUPERS; s++)
    begin : gen_super
        assign blk_c[4 * s +: 4] = la_carries(blk_g[4 * s +: 4], blk_p[4 * s +: 4], sup_c[s]);
        assign {sup_g[s], sup_p[s]} = la_group(blk_g[4 * s +: 4], blk_p[4 * s +: 4]);
    end

    // superblock carries, no carry-in and the top carry-out is dropped
    always_comb
    begin
        sup_c[0] = 1'b0;
        for (int s = 1; s < LA_SUPERS; s++)
        begin
            sup_c[s] = sup_g[s-1] | (sup_p[s-1] & sup_c[s-1]);
        end
    end

    assign sum = prop ^ carry;

endmodule

/* src/mult_pkg.sv */
// arithmetic widths, counts and vector types for the booth multiplier datapath
package mult_pkg;

    // ----------------------------------------------------------------------
    // operand and product widths
    localparam int OPERAND_W = 64;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // operand plus two bits, enough for the +-2X range
    localparam int EXT_W = OPERAND_W + 2;

    // one digit per bit pair, plus the top digit of an unsigned multiplier
    localparam int NUM_PP = OPERAND_W / 2 + 1;

    // extended row with the two sign compression bits
    localparam int PP_W = EXT_W + 2;

    // partial products plus the row of low sign bits
    localparam int TREE_ROWS = NUM_PP + 1;

    // carry lookahead grouping
    localparam int LA_GROUP_W = 4;
    localparam int LA_BLOCKS = PRODUCT_W / LA_GROUP_W;
    localparam int LA_SUPERS = LA_BLOCKS / LA_GROUP_W;

    // ----------------------------------------------------------------------
    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_t;
    typedef logic [EXT_W-1:0] ext_operand_t;
    typedef logic [PP_W-1:0] pp_row_t;
    typedef logic [2:0] booth_digit_t;
    typedef logic [LA_GROUP_W-1:0] la_group_t;

    // rows left after a given number of 3:2 levels
    function automatic int tree_rows(int level);
        int n;
        n = TREE_ROWS;
        for (int l = 0; l < level; l++)
        begin
            n = (n / 3) * 2 + n % 3;
        end
        return n;
    endfunction

    // levels needed to get down to two rows
    function automatic int tree_levels();
        int l;
        l = 0;
        while (tree_rows(l) > 2)
        begin
            l++;
        end
        return l;
    endfunction

    localparam int TREE_LEVELS = tree_levels();

endpackage

/* src/pp_skid_buffer.sv */
// two-entry fifo for partial product sets, decouples the request stream from output stalls
module pp_skid_buffer
    import stream_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  pp_set_t set_in,
    input  logic    in_valid,
    output logic    in_ready,
    output pp_set_t set_out,
    output logic    out_valid,
    input  logic    out_ready
);

    // 0, 1 or 2 entries held
    logic [1:0] fill;
    pp_set_t    head;
    pp_set_t    tail;
    logic       push;
    logic       pop;

    // ----------------------------------------------------------------------
    // handshakes

    assign in_ready  = (fill != 2'd2);
    assign out_valid = (fill != 2'd0);
    assign set_out   = head;

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            fill <= 2'd0;
        end
        else
        begin
            case ({push, pop})
                2'b10:   fill <= fill + 2'd1;
                2'b01:   fill <= fill - 2'd1;
                default: fill <= fill;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // storage

    // head is always the oldest entry
    always_ff @(posedge clk)
    begin
        if (push && (fill == 2'd0 || (fill == 2'd1 && pop)))
        begin
            head <= set_in;
        end
        else if (pop && fill == 2'd2)
        begin
            head <= tail;
        end

        // second entry only fills while head is stalled
        if (push && fill == 2'd1 && !pop)
        begin
            tail <= set_in;
        end
    end

endmodule

/* src/stream_pkg.sv */
// packed structs carried on the operand stream and the partial product stream
package stream_pkg;

    import mult_pkg::*;

    // ----------------------------------------------------------------------
    // one operation on the input stream
    typedef struct packed {
        operand_t multiplicand;
        operand_t multiplier;
        // 1 for two's complement operands
        logic     signed_mode;
    } mult_req_t;

    // ----------------------------------------------------------------------
    // one operation's partial products, between recoder and reducer
    typedef struct packed {
        pp_row_t [NUM_PP-1:0] rows;
        // +1 that completes each one's complement row
        logic [NUM_PP-1:0]    sign_low;
    } pp_set_t;

endpackage

/* src/wallace_reducer.sv */
// carry-save reduction of a partial product set, final add and the registered product
module wallace_reducer
    import mult_pkg::*;
    import stream_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  pp_set_t  set_in,
    input  logic     set_valid,
    output logic     set_ready,
    output product_t product,
    output logic     product_valid,
    input  logic     product_ready
);

    product_t sign_row;
    product_t sum_row;
    product_t carry_row;
    product_t adder_sum;
    logic     take;

    // ----------------------------------------------------------------------
    // column frame

    // low sign bits sit at the lsb of their own row
    always_comb
    begin
        sign_row = '0;
        for (int i = 0; i < NUM_PP; i++)
        begin
            sign_row[2 * i] = set_in.sign_low[i];
        end
    end

    // ----------------------------------------------------------------------
    // 3:2 levels, level 0 is the shifted frame itself
    for (genvar lvl = 0; lvl <= TREE_LEVELS; lvl++)
    begin : gen_level
        product_t rows [TREE_ROWS];

        if (lvl == 0)
        begin : gen_frame
            // row i weighs 4^i, bits past the product width drop out
            for (genvar i = 0; i < NUM_PP; i++)
            begin : gen_place
                assign rows[i] = product_t'(set_in.rows[i]) << (2 * i);
            end
            assign rows[NUM_PP] = sign_row;
        end
        else
        begin : gen_reduce
            for (genvar k = 0; k < tree_rows(lvl - 1) / 3; k++)
            begin : gen_counter
                product_t x;
                product_t y;
                product_t z;

                assign x = gen_level[lvl-1].rows[3 * k];
                assign y = gen_level[lvl-1].rows[3 * k + 1];
                assign z = gen_level[lvl-1].rows[3 * k + 2];

                assign rows[2 * k]     = x ^ y ^ z;
                // majority moves one column up
                assign rows[2 * k + 1] = ((x & y) | (x & z) | (y & z)) << 1;
            end

            // leftover rows skip this level
            for (genvar r = 0; r < tree_rows(lvl - 1) % 3; r++)
            begin : gen_pass
                assign rows[2 * (tree_rows(lvl - 1) / 3) + r] =
                    gen_level[lvl-1].rows[3 * (tree_rows(lvl - 1) / 3) + r];
            end

            for (genvar u = tree_rows(lvl); u < TREE_ROWS; u++)
            begin : gen_unused
                assign rows[u] = '0;
            end
        end
    end

    assign sum_row   = gen_level[TREE_LEVELS].rows[0];
    assign carry_row = gen_level[TREE_LEVELS].rows[1];

    cla_adder cla_adder_i (
        .a   (sum_row),
        .b   (carry_row),
        .sum (adder_sum)
    );

    // ----------------------------------------------------------------------
    // output register

    // accept when empty or draining this cycle
    assign set_ready = ~product_valid | product_ready;
    assign take      = set_valid & set_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            product_valid <= 1'b0;
        end
        else
        begin
            product_valid <= take | (product_valid & ~product_ready);
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            product <= adder_sum;
        end
    end

endmodule

/* test/tb_booth_mult.sv */
// testbench for the booth multiplier that streams directed and random operations and checks products
module tb_booth_mult
    import mult_pkg::*;
    import stream_pkg::*;
();

    localparam int HALF_PERIOD    = 50;
    localparam int DRIVE_DELAY    = 10;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SETTLE_CYCLES  = 8;
    localparam int RANDOM_OPS     = 300;
    localparam int TOGGLE_OPS     = 200;
    localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;
    localparam operand_t ALL_ONES = {OPERAND_W{1'b1}};
    localparam operand_t MOST_NEG = {1'b1, {(OPERAND_W-1){1'b0}}};

    logic      clk;
    logic      rst_n;
    mult_req_t req;
    logic      req_valid;
    logic      req_ready;
    product_t  product;
    logic      product_valid;
    logic      product_ready;

    logic [31:0] lfsr_state;
    logic        toggle_ready;
    product_t    expected_q[$];
    product_t    expected;
    int          accept_count;
    int          product_count;
    int          check_count;
    int          error_count;

    booth_mult_top booth_mult_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .product       (product),
        .product_valid (product_valid),
        .product_ready (product_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // random source and reference model

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // full product of the extended operands truncated to 128 bits
    function automatic product_t model_product(
        input operand_t a,
        input operand_t b,
        input logic     s
    );
        product_t ea;
        product_t eb;
        ea = {{OPERAND_W{s & a[OPERAND_W-1]}}, a};
        eb = {{OPERAND_W{s & b[OPERAND_W-1]}}, b};
        return ea * eb;
    endfunction

    // ----------------------------------------------------------------------
    // stream monitor that records requests and compares products in order
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (req_valid && req_ready)
            begin
                expected_q.push_back(model_product(req.multiplicand, req.multiplier,
                                                   req.signed_mode));
                accept_count++;
            end
            if (product_valid && product_ready)
            begin
                product_count++;
                if (expected_q.size() == 0)
                begin
                    $display("product transfer seen with no request outstanding");
                    error_count++;
                end
                else
                begin
                    expected = expected_q.pop_front();
                    check_count++;
                    if (product !== expected)
                    begin
                        $display("FAILED product: expected %h, got %h", expected, product);
                        error_count++;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // driver tasks called a drive delay after an edge

    task automatic next_cycle();
        logic [63:0] bits;
        @(posedge clk);
        #DRIVE_DELAY;
        if (toggle_ready)
        begin
            bits = rand_bits(1);
            product_ready = bits[0];
        end
    endtask

    task automatic load_req(input operand_t a, input operand_t b, input logic s);
        req.multiplicand = a;
        req.multiplier   = b;
        req.signed_mode  = s;
        req_valid        = 1'b1;
    endtask

    task automatic wait_accept(input int start);
        int waited;
        waited = 0;
        while (accept_count == start && waited < TIMEOUT_CYCLES)
        begin
            next_cycle();
            waited++;
        end
        if (accept_count == start)
        begin
            $display("timeout: request not accepted within %0d cycles", TIMEOUT_CYCLES);
            error_count++;
        end
        req_valid = 1'b0;
    endtask

    task automatic send_op(input operand_t a, input operand_t b, input logic s);
        int start;
        start = accept_count;
        load_req(a, b, s);
        wait_accept(start);
    endtask

    task automatic send_random();
        operand_t    a;
        operand_t    b;
        logic [63:0] bits;
        a = rand_bits(OPERAND_W);
        b = rand_bits(OPERAND_W);
        bits = rand_bits(1);
        send_op(a, b, bits[0]);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < TIMEOUT_CYCLES)
        begin
            next_cycle();
            waited++;
        end
        if (expected_q.size() != 0)
        begin
            $display("timeout: %0d products never came out", expected_q.size());
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    initial
    begin : main
        int e0;
        int a0;
        int p0;

        rst_n = 1'b0;
        req = '0;
        req_valid = 1'b0;
        product_ready = 1'b1;
        toggle_ready = 1'b0;
        lfsr_state = 32'd94;
        accept_count = 0;
        product_count = 0;
        check_count = 0;
        error_count = 0;

        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // idle state after reset
        e0 = error_count;
        next_cycle();
        check_count += 2;
        if (product_valid !== 1'b0)
        begin
            $display("FAILED product_valid: expected 0, got %h", product_valid);
            error_count++;
        end
        if (req_ready !== 1'b1)
        begin
            $display("FAILED req_ready: expected 1, got %h", req_ready);
            error_count++;
        end
        report_test("reset state", e0);

        e0 = error_count;
        send_op('0, 64'h1234_5678_9ABC_DEF0, 1'b0);
        send_op(ALL_ONES, '0, 1'b0);
        send_op(ALL_ONES, ALL_ONES, 1'b0);
        send_op(MOST_NEG, ALL_ONES, 1'b0);
        send_op(64'h0000_0000_0002_0000, ALL_ONES, 1'b0);
        send_op(64'hAAAA_AAAA_AAAA_AAAA, 64'h5555_5555_5555_5555, 1'b0);
        send_op(64'hAAAA_AAAA_AAAA_AAAA, 64'hAAAA_AAAA_AAAA_AAAA, 1'b0);
        send_op(64'h5555_5555_5555_5555, 64'h5555_5555_5555_5555, 1'b0);
        wait_drain();
        report_test("unsigned corners", e0);

        e0 = error_count;
        send_op(MOST_NEG, MOST_NEG, 1'b1);
        send_op(MOST_NEG, ALL_ONES, 1'b1);
        send_op(MOST_NEG, 64'd1, 1'b1);
        send_op(ALL_ONES, ALL_ONES, 1'b1);
        send_op(64'hFFFF_FFFF_FFFF_FFFB, 64'd7, 1'b1);
        send_op(64'd123456789, -64'd987654321, 1'b1);
        send_op({1'b0, {(OPERAND_W-1){1'b1}}}, MOST_NEG, 1'b1);
        wait_drain();
        report_test("signed corners", e0);

        e0 = error_count;
        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            send_random();
        end
        wait_drain();
        report_test("random back to back", e0);

        // stalled output holds three operations in the pipeline
        e0 = error_count;
        a0 = accept_count;
        product_ready = 1'b0;
        for (int i = 0; i < 3; i++)
        begin
            send_random();
        end
        check_count += 2;
        if (req_ready !== 1'b0)
        begin
            $display("FAILED req_ready: expected 0, got %h", req_ready);
            error_count++;
        end
        load_req(64'hDEAD_BEEF_0BAD_F00D, 64'h0123_4567_89AB_CDEF, 1'b1);
        repeat (8) next_cycle();
        if (accept_count - a0 != 3)
        begin
            $display("FAILED accepted count: expected %h, got %h", 3, accept_count - a0);
            error_count++;
        end
        product_ready = 1'b1;
        wait_accept(a0 + 3);
        wait_drain();
        report_test("output stall", e0);

        e0 = error_count;
        a0 = accept_count;
        p0 = product_count;
        toggle_ready = 1'b1;
        for (int i = 0; i < TOGGLE_OPS; i++)
        begin
            send_random();
        end
        toggle_ready = 1'b0;
        product_ready = 1'b1;
        wait_drain();
        // a duplicated product would still arrive in this window
        repeat (SETTLE_CYCLES) next_cycle();
        check_count++;
        if (product_count - p0 != accept_count - a0)
        begin
            $display("FAILED product count: expected %h, got %h",
                     accept_count - a0, product_count - p0);
            error_count++;
        end
        report_test("random ready", e0);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
